/* hdl/mt_pkg.sv */
// package mt_pkg: pipeline widths, op-code constants, pipeline structs and immediate sign extension
`default_nettype none

package mt_pkg;

    typedef logic [31:0] word_t;        // data word and program counter
    typedef logic [4:0]  reg_idx_t;     // r0 is an ordinary register here
    typedef logic [2:0]  thread_id_t;
    typedef logic [15:0] imm_t;
    typedef logic [2:0]  alu_op_t;
    typedef logic [3:0]  jmp_cond_t;
    typedef logic [1:0]  mem_ctrl_t;
    typedef logic [1:0]  fwd_src_t;

    // *******************************************************************
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLT = 3'd5;
    localparam alu_op_t ALU_SLL = 3'd6;
    localparam alu_op_t ALU_SRL = 3'd7;

    localparam jmp_cond_t JC_NONE = 4'd0;
    localparam jmp_cond_t JC_BEQ  = 4'd1;
    localparam jmp_cond_t JC_BNE  = 4'd2;
    localparam jmp_cond_t JC_BLT  = 4'd3;
    localparam jmp_cond_t JC_JAL  = 4'd4;   // pc relative, links
    localparam jmp_cond_t JC_JR   = 4'd5;   // jumps to operand a, links

    localparam mem_ctrl_t MC_NONE  = 2'd0;
    localparam mem_ctrl_t MC_LOAD  = 2'd1;
    localparam mem_ctrl_t MC_STORE = 2'd2;

    localparam fwd_src_t FWD_REG = 2'd0;    // value as read by decode
    localparam fwd_src_t FWD_MEM = 2'd1;
    localparam fwd_src_t FWD_WB  = 2'd2;

    // *******************************************************************
    // decoded instruction entering execute
    typedef struct packed {
        logic       valid;
        thread_id_t tid;
        word_t      pc;
        word_t      op_a;
        word_t      op_b;
        reg_idx_t   src_a;
        reg_idx_t   src_b;
        imm_t       imm;
        logic       i_type;
        alu_op_t    alu_op;
        jmp_cond_t  jmp_cond;
        mem_ctrl_t  mem_ctrl;
        reg_idx_t   rd;
        logic       wr_en;
        logic       init_thread;
        thread_id_t new_tid;
    } ex_req_t;

    typedef struct packed {
        logic       valid;
        thread_id_t tid;
        word_t      pc;
        word_t      result;         // also the memory address
        word_t      store_data;
        reg_idx_t   rd;
        logic       wr_en;
        mem_ctrl_t  mem_ctrl;
        thread_id_t target_tid;     // thread a thread-control op acts on
    } ex_mem_t;

    typedef struct packed {
        logic       valid;
        thread_id_t tid;
        reg_idx_t   rd;
        logic       wr_en;
        word_t      data;
    } wb_t;

    typedef struct packed {
        fwd_src_t a;
        fwd_src_t b;
    } fwd_sel_t;

    function automatic word_t sext_imm(imm_t imm);
        return {{16{imm[15]}}, imm};
    endfunction

endpackage

`default_nettype wire

/* hdl/alu.sv */
// module alu: integer ALU with equal and signed less-than flags and add/sub overflow
`timescale 1ns/100ps
`default_nettype none

module alu import mt_pkg::*; (
    input  wire word_t   a,
    input  wire word_t   b,
    input  wire alu_op_t op,
    output word_t        result,
    output logic         eq,
    output logic         lt,
    output logic         overflow
);

    word_t sum;
    word_t diff;
    logic  add_ovf;
    logic  sub_ovf;

    assign sum  = a + b;
    assign diff = a - b;

    // signed overflow shows as a result sign that the operand signs cannot give
    assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]);
    assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

    assign eq = (a == b);
    assign lt = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            ALU_ADD: result = sum;
            ALU_SUB: result = diff;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = word_t'(lt);
            ALU_SLL: result = a << b[4:0];
            ALU_SRL: result = a >> b[4:0];  // logical shift
            default: result = sum;
        endcase
    end

    always_comb begin
        case (op)
            ALU_ADD: overflow = add_ovf;
            ALU_SUB: overflow = sub_ovf;
            default: overflow = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/branch_unit.sv */
// module branch_unit: jump target and taken decision from condition code and ALU flags
`timescale 1ns/100ps
`default_nettype none

module branch_unit import mt_pkg::*; (
    input  wire word_t     pc,
    input  wire imm_t      imm,
    input  wire word_t     a,
    input  wire jmp_cond_t cond,
    input  wire            eq,
    input  wire            lt,
    output word_t          jmp_pc,
    output logic           jmp_en
);

    word_t rel_target;

    // branches and JAL use a word offset
    assign rel_target = pc + (sext_imm(imm) << 2);
    assign jmp_pc     = (cond == JC_JR) ? a : rel_target;

    // the flags come from the operand compare, decode sets ALU_SUB for branches
    always_comb begin
        case (cond)
            JC_BEQ:  jmp_en = eq;
            JC_BNE:  jmp_en = !eq;
            JC_BLT:  jmp_en = lt;
            JC_JAL:  jmp_en = 1'b1;
            JC_JR:   jmp_en = 1'b1;
            default: jmp_en = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/hazard_ctrl.sv */
// module hazard_ctrl: per-thread operand forwarding select and load-use stall
`timescale 1ns/100ps
`default_nettype none

module hazard_ctrl import mt_pkg::*; (
    input  wire ex_req_t ex_req,
    input  wire ex_mem_t ex_mem,
    input  wire wb_t     wb,
    output fwd_sel_t     fwd_sel,
    output logic         stall
);

    logic mem_hit_a;
    logic mem_hit_b;
    logic wb_hit_a;
    logic wb_hit_b;
    logic mem_is_load;

    // a producer only matches within the same thread
    function automatic logic mem_match(ex_mem_t m, thread_id_t tid, reg_idx_t src);
        return m.valid && m.wr_en && (m.tid == tid) && (m.rd == src);
    endfunction

    function automatic logic wb_match(wb_t w, thread_id_t tid, reg_idx_t src);
        return w.valid && w.wr_en && (w.tid == tid) && (w.rd == src);
    endfunction

    function automatic fwd_src_t pick(logic mem_hit, logic wb_hit);
        if (mem_hit) begin
            return FWD_MEM;                 // youngest producer wins
        end
        return wb_hit ? FWD_WB : FWD_REG;
    endfunction

    assign mem_hit_a   = mem_match(ex_mem, ex_req.tid, ex_req.src_a);
    assign mem_hit_b   = mem_match(ex_mem, ex_req.tid, ex_req.src_b);
    assign wb_hit_a    = wb_match(wb, ex_req.tid, ex_req.src_a);
    assign wb_hit_b    = wb_match(wb, ex_req.tid, ex_req.src_b);
    assign mem_is_load = (ex_mem.mem_ctrl == MC_LOAD);

    // load data only exists after the MEM cycle, so a dependent op waits one cycle
    assign stall = ex_req.valid && mem_is_load && (mem_hit_a || mem_hit_b);

    always_comb begin
        fwd_sel.a = pick(mem_hit_a, wb_hit_a);
        fwd_sel.b = pick(mem_hit_b, wb_hit_b);
        if (stall) begin
            fwd_sel = '{a: FWD_REG, b: FWD_REG};   // operands are dropped anyway
        end
    end

endmodule

`default_nettype wire

/* hdl/exe_stage.sv */
// module exe_stage: operand forwarding, ALU and branch units, result select and EX/MEM register
`timescale 1ns/100ps
`default_nettype none

module exe_stage import mt_pkg::*; (
    input  wire           clk,
    input  wire           rst_n,
    input  wire ex_req_t  ex_req,
    input  wire fwd_sel_t fwd_sel,
    input  wire           stall,
    input  wire           flush,
    input  wire wb_t      wb,
    output ex_mem_t       ex_mem,
    output word_t         jmp_pc,
    output logic          jmp_en,
    output logic          overflow
);

    word_t   op_a;
    word_t   op_b;
    word_t   alu_b;
    word_t   alu_out;
    word_t   result;
    logic    eq;
    logic    lt;
    logic    alu_ovf;
    logic    bu_jmp_en;
    logic    accept;
    logic    link;
    ex_mem_t ex_next;

    function automatic word_t fwd_mux(fwd_src_t sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign op_a  = fwd_mux(fwd_sel.a, ex_req.op_a, ex_mem.result, wb.data);
    assign op_b  = fwd_mux(fwd_sel.b, ex_req.op_b, ex_mem.result, wb.data);
    assign alu_b = ex_req.i_type ? sext_imm(ex_req.imm) : op_b;

    alu i_alu (
        .a        (op_a),
        .b        (alu_b),
        .op       (ex_req.alu_op),
        .result   (alu_out),
        .eq       (eq),
        .lt       (lt),
        .overflow (alu_ovf)
    );

    branch_unit i_branch (
        .pc     (ex_req.pc),
        .imm    (ex_req.imm),
        .a      (op_a),
        .cond   (ex_req.jmp_cond),
        .eq     (eq),
        .lt     (lt),
        .jmp_pc (jmp_pc),
        .jmp_en (bu_jmp_en)
    );

    // a held request has stale operands until the stall clears
    assign accept   = ex_req.valid && !stall;
    assign jmp_en   = bu_jmp_en && accept;
    assign overflow = alu_ovf && accept;

    assign link   = (ex_req.jmp_cond == JC_JAL) || (ex_req.jmp_cond == JC_JR);
    assign result = ex_req.init_thread ? word_t'(ex_req.new_tid) :
                    link               ? ex_req.pc + 32'd4 :
                                         alu_out;

    always_comb begin
        ex_next.valid      = accept;
        ex_next.tid        = ex_req.tid;
        ex_next.pc         = ex_req.pc;
        ex_next.result     = result;
        ex_next.store_data = op_b;
        ex_next.rd         = ex_req.rd;
        ex_next.wr_en      = ex_req.wr_en;
        ex_next.mem_ctrl   = ex_req.mem_ctrl;
        ex_next.target_tid = op_a[2:0];
    end

    // *******************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= ex_next;
            if (flush) begin
                ex_mem.valid <= 1'b0;
            end
        end
    end

    // an accepted op never takes the address of a load in EX/MEM as its operand
    a_no_load_forward: assert property (
        @(posedge clk) disable iff (!rst_n)
        (accept && ((fwd_sel.a == FWD_MEM) || (fwd_sel.b == FWD_MEM)))
            |-> (ex_mem.mem_ctrl != MC_LOAD)
    );

endmodule

`default_nettype wire

/* hdl/mem_wb_stage.sv */
// module mem_wb_stage: data memory for loads and stores and the MEM/WB register driving writeback
`timescale 1ns/100ps
`default_nettype none

module mem_wb_stage import mt_pkg::*; #(
    parameter int DMEM_WORDS = 64
) (
    input  wire          clk,
    input  wire          rst_n,
    input  wire ex_mem_t ex_mem,
    output wb_t          wb
);

    localparam int ADDR_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    word_t             dmem [DMEM_WORDS];
    word_t             word_idx;
    logic [ADDR_W-1:0] addr;
    logic              is_load;
    logic              is_store;

    // byte address to word index, wrapped onto the memory depth
    assign word_idx = ex_mem.result >> 2;
    assign addr     = ADDR_W'(word_idx % DMEM_WORDS);

    assign is_load  = ex_mem.valid && (ex_mem.mem_ctrl == MC_LOAD);
    assign is_store = ex_mem.valid && (ex_mem.mem_ctrl == MC_STORE);

    // *******************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (is_store) begin
            dmem[addr] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb.valid <= ex_mem.valid;
            wb.tid   <= ex_mem.tid;
            wb.rd    <= ex_mem.rd;
            wb.wr_en <= ex_mem.wr_en;
            wb.data  <= is_load ? dmem[addr] : ex_mem.result;   // read during MEM
        end
    end

    a_load_writes: assert property (
        @(posedge clk) disable iff (!rst_n) is_load |-> ex_mem.wr_en
    );

endmodule

`default_nettype wire

/* hdl/exe_top.sv */
// module exe_top: hazard controller, execute stage and memory/writeback stage
`timescale 1ns/100ps
`default_nettype none

module exe_top import mt_pkg::*; #(
    parameter int DMEM_WORDS = 64
) (
    input  wire          clk,
    input  wire          rst_n,
    input  wire ex_req_t ex_req,
    input  wire          flush,
    output word_t        jmp_pc,
    output logic         jmp_en,
    output logic         overflow,
    output logic         stall,
    output ex_mem_t      ex_mem,
    output wb_t          wb
);

    fwd_sel_t fwd_sel;

    hazard_ctrl i_hazard (
        .ex_req  (ex_req),
        .ex_mem  (ex_mem),
        .wb      (wb),
        .fwd_sel (fwd_sel),
        .stall   (stall)
    );

    exe_stage i_exe (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_req   (ex_req),
        .fwd_sel  (fwd_sel),
        .stall    (stall),
        .flush    (flush),
        .wb       (wb),
        .ex_mem   (ex_mem),
        .jmp_pc   (jmp_pc),
        .jmp_en   (jmp_en),
        .overflow (overflow)
    );

    mem_wb_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) i_mem_wb (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_mem (ex_mem),
        .wb     (wb)
    );

endmodule

`default_nettype wire

/* verification/exe_tb.sv */
// module exe_tb: random-stimulus testbench with a reference pipeline model, watchdog and report
`timescale 1ns/100ps
`default_nettype none

module exe_tb import mt_pkg::*;;

    localparam int DMEM_WORDS = 64;
    localparam int N_ALU = 40;
    localparam int N_FWD = 40;
    localparam int N_THR = 15;              // pairs of requests
    localparam int N_LDU = 8;               // five requests each
    localparam int N_BR  = 40;
    localparam int N_FL  = 20;
    localparam int N_REQ = N_ALU + N_FWD + 2 * N_THR + 5 * N_LDU + N_BR + N_FL + 6 * 3;
    localparam int WATCHDOG_CYCLES = N_REQ * 4 + 50;

    typedef struct packed {
        logic       valid;
        thread_id_t tid;
        reg_idx_t   rd;
        logic       wr_en;
        logic       is_load;
        word_t      data;
        word_t      pc;
        word_t      result;
        word_t      store_data;
        mem_ctrl_t  mem_ctrl;
        thread_id_t target_tid;
    } stage_t;

    logic    clk = 1'b0;
    logic    rst_n;
    ex_req_t ex_req;
    logic    flush;
    word_t   jmp_pc;
    logic    jmp_en;
    logic    overflow;
    logic    stall;
    ex_mem_t ex_mem;
    wb_t     wb;

    word_t  arch_rf [8][32];        // program-order register state
    word_t  committed_rf [8][32];   // what decode reads, behind by the in-flight writes
    word_t  dmem_model [DMEM_WORDS];
    stage_t exp_mem;
    stage_t exp_wb;
    string  cur_test;
    int     test_errs;
    int     n_pass;
    int     n_fail;

    exe_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_req   (ex_req),
        .flush    (flush),
        .jmp_pc   (jmp_pc),
        .jmp_en   (jmp_en),
        .overflow (overflow),
        .stall    (stall),
        .ex_mem   (ex_mem),
        .wb       (wb)
    );

    always #5 clk = ~clk;

    // ******************************************************************
    // reference model

    function automatic word_t imm_ext(imm_t imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic word_t alu_model(word_t a, word_t b, alu_op_t op);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLL: return a << b[4:0];
            default: return a >> b[4:0];
        endcase
    endfunction

    // exact sum in 64 bits, overflow when it leaves the 32-bit signed range
    function automatic logic overflow_model(word_t a, word_t b, alu_op_t op);
        longint wide;
        if (op == ALU_ADD) begin
            wide = longint'($signed(a)) + longint'($signed(b));
        end else if (op == ALU_SUB) begin
            wide = longint'($signed(a)) - longint'($signed(b));
        end else begin
            return 1'b0;
        end
        return (wide > 64'sh7fff_ffff) || (wide < -64'sh8000_0000);
    endfunction

    function automatic logic taken_model(jmp_cond_t c, word_t a, word_t b);
        case (c)
            JC_BEQ:        return a == b;
            JC_BNE:        return a != b;
            JC_BLT:        return $signed(a) < $signed(b);
            JC_JAL, JC_JR: return 1'b1;
            default:       return 1'b0;
        endcase
    endfunction

    task automatic report_mismatch(string what, word_t expected, word_t actual);
        $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, expected, actual);
        test_errs++;
    endtask

    task automatic check_wb();
        if (wb.valid !== exp_wb.valid) begin
            report_mismatch("wb valid", 32'(exp_wb.valid), 32'(wb.valid));
        end else if (exp_wb.valid) begin
            if (wb.tid !== exp_wb.tid) report_mismatch("wb tid", 32'(exp_wb.tid), 32'(wb.tid));
            if (wb.rd !== exp_wb.rd) report_mismatch("wb rd", 32'(exp_wb.rd), 32'(wb.rd));
            if (wb.wr_en !== exp_wb.wr_en) begin
                report_mismatch("wb wr_en", 32'(exp_wb.wr_en), 32'(wb.wr_en));
            end
            if (wb.data !== exp_wb.data) report_mismatch("wb data", exp_wb.data, wb.data);
        end
        if (exp_wb.valid && exp_wb.wr_en) begin
            committed_rf[exp_wb.tid][exp_wb.rd] = exp_wb.data;
        end
    endtask

    task automatic check_ex_mem();
        if (ex_mem.valid !== exp_mem.valid) begin
            report_mismatch("ex_mem valid", 32'(exp_mem.valid), 32'(ex_mem.valid));
        end else if (exp_mem.valid) begin
            if (ex_mem.pc !== exp_mem.pc) begin
                report_mismatch("ex_mem pc", exp_mem.pc, ex_mem.pc);
            end
            if (ex_mem.result !== exp_mem.result) begin
                report_mismatch("ex_mem result", exp_mem.result, ex_mem.result);
            end
            if (ex_mem.store_data !== exp_mem.store_data) begin
                report_mismatch("ex_mem store_data", exp_mem.store_data, ex_mem.store_data);
            end
            if (ex_mem.mem_ctrl !== exp_mem.mem_ctrl) begin
                report_mismatch("ex_mem mem_ctrl", 32'(exp_mem.mem_ctrl), 32'(ex_mem.mem_ctrl));
            end
            if (ex_mem.target_tid !== exp_mem.target_tid) begin
                report_mismatch("ex_mem target_tid", 32'(exp_mem.target_tid),
                                32'(ex_mem.target_tid));
            end
        end
    endtask

    task automatic check_execute();
        word_t       a;
        word_t       b_reg;
        word_t       b;
        word_t       res;
        word_t       target;
        logic        exp_stall;
        logic        accept;
        logic        exp_ovf;
        logic        exp_jmp;
        int unsigned idx;
        stage_t      nxt;
        a      = arch_rf[ex_req.tid][ex_req.src_a];
        b_reg  = arch_rf[ex_req.tid][ex_req.src_b];
        b      = ex_req.i_type ? imm_ext(ex_req.imm) : b_reg;
        exp_stall = ex_req.valid && exp_mem.valid && exp_mem.wr_en && exp_mem.is_load
                    && (exp_mem.tid == ex_req.tid)
                    && ((exp_mem.rd == ex_req.src_a) || (exp_mem.rd == ex_req.src_b));
        accept  = ex_req.valid && !exp_stall;
        exp_ovf = accept && overflow_model(a, b, ex_req.alu_op);
        exp_jmp = accept && taken_model(ex_req.jmp_cond, a, b);
        target  = (ex_req.jmp_cond == JC_JR) ? a : ex_req.pc + (imm_ext(ex_req.imm) << 2);
        if (stall !== exp_stall) report_mismatch("stall", 32'(exp_stall), 32'(stall));
        if (overflow !== exp_ovf) report_mismatch("overflow", 32'(exp_ovf), 32'(overflow));
        if (jmp_en !== exp_jmp) report_mismatch("jmp_en", 32'(exp_jmp), 32'(jmp_en));
        if (exp_jmp && (jmp_pc !== target)) report_mismatch("jmp_pc", target, jmp_pc);

        if (ex_req.init_thread) begin
            res = 32'(ex_req.new_tid);
        end else if ((ex_req.jmp_cond == JC_JAL) || (ex_req.jmp_cond == JC_JR)) begin
            res = ex_req.pc + 32'd4;    // link address
        end else begin
            res = alu_model(a, b, ex_req.alu_op);
        end
        idx = (res >> 2) % DMEM_WORDS;
        nxt = '0;
        if (accept && !flush) begin
            nxt.valid      = 1'b1;
            nxt.tid        = ex_req.tid;
            nxt.rd         = ex_req.rd;
            nxt.wr_en      = ex_req.wr_en;
            nxt.is_load    = (ex_req.mem_ctrl == MC_LOAD);
            nxt.data       = nxt.is_load ? dmem_model[idx] : res;
            nxt.pc         = ex_req.pc;
            nxt.result     = res;
            nxt.store_data = b_reg;
            nxt.mem_ctrl   = ex_req.mem_ctrl;
            nxt.target_tid = a[2:0];
            if (ex_req.mem_ctrl == MC_STORE) dmem_model[idx] = b_reg;
            if (ex_req.wr_en) arch_rf[ex_req.tid][ex_req.rd] = nxt.data;
        end
        exp_wb  = exp_mem;
        exp_mem = nxt;
    endtask

    // outputs are settled half a cycle after the driving edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_wb();
            check_ex_mem();
            check_execute();
        end
    end

    // ******************************************************************
    // stimulus

    function automatic ex_req_t make_req(thread_id_t tid, reg_idx_t rd, reg_idx_t sa, reg_idx_t sb);
        ex_req_t r;
        r        = '0;
        r.valid  = 1'b1;
        r.tid    = tid;
        r.pc     = $urandom & 32'hffff_fffc;
        r.src_a  = sa;
        r.src_b  = sb;
        r.op_a   = committed_rf[tid][sa];
        r.op_b   = committed_rf[tid][sb];
        r.imm    = imm_t'($urandom);
        r.i_type = $urandom_range(1, 0);
        r.alu_op = alu_op_t'($urandom);
        r.rd     = rd;
        r.wr_en  = 1'b1;
        return r;
    endfunction

    // holds the request while stall is up, returns on the edge that accepts it
    task automatic issue(ex_req_t r, logic fl);
        ex_req <= r;
        flush  <= fl;
        @(negedge clk);
        while (stall) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic begin_test(string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        repeat (3) issue('0, 1'b0);
        $display("test %s: %0d errors", cur_test, test_errs);
        if (test_errs == 0) n_pass++;
        else n_fail++;
    endtask

    task automatic random_alu_ops();
        ex_req_t r;
        begin_test("alu_results");
        for (int i = 0; i < N_ALU; i++) begin
            r = make_req(thread_id_t'($urandom), reg_idx_t'($urandom_range(31, 16)),
                         reg_idx_t'($urandom_range(15, 0)), reg_idx_t'($urandom_range(15, 0)));
            issue(r, 1'b0);
        end
        end_test();
    endtask

    task automatic dependent_chains();
        ex_req_t    r;
        thread_id_t t;
        begin_test("forwarding");
        for (int i = 0; i < N_FWD; i++) begin
            if (i % 10 == 0) t = $urandom;
            // four registers only, so most ops depend on one or two ops back
            r = make_req(t, reg_idx_t'($urandom_range(3, 0)), reg_idx_t'($urandom_range(3, 0)),
                         reg_idx_t'($urandom_range(3, 0)));
            issue(r, 1'b0);
        end
        end_test();
    endtask

    task automatic thread_isolation();
        ex_req_t    r;
        thread_id_t t1;
        thread_id_t t2;
        reg_idx_t   shared;
        begin_test("thread_isolation");
        for (int i = 0; i < N_THR; i++) begin
            t1     = $urandom;
            t2     = t1 + thread_id_t'($urandom_range(7, 1));
            shared = $urandom;
            r = make_req(t1, shared, reg_idx_t'($urandom), reg_idx_t'($urandom));
            issue(r, 1'b0);
            r = make_req(t2, reg_idx_t'($urandom), shared, shared);
            issue(r, 1'b0);
        end
        end_test();
    endtask

    task automatic load_use();
        ex_req_t    r;
        thread_id_t t;
        reg_idx_t   base;
        reg_idx_t   data;
        reg_idx_t   ld;
        imm_t       off;
        begin_test("load_use");
        for (int i = 0; i < N_LDU; i++) begin
            t    = $urandom;
            base = $urandom_range(7, 0);
            data = $urandom_range(15, 8);
            ld   = $urandom_range(23, 16);
            off  = imm_t'($urandom_range(15, 0) * 4);
            // drain the thread so that only the load is in flight at the dependent op
            issue('0, 1'b0);
            issue('0, 1'b0);
            r = make_req(t, 5'd0, base, data);
            r.i_type   = 1'b1;
            r.alu_op   = ALU_ADD;
            r.imm      = off;
            r.mem_ctrl = MC_STORE;
            r.wr_en    = 1'b0;
            issue(r, 1'b0);
            r = make_req(t, ld, base, base);
            r.i_type   = 1'b1;
            r.alu_op   = ALU_ADD;
            r.imm      = (i % 2 == 0) ? off : imm_t'($urandom_range(15, 0) * 4);
            r.mem_ctrl = MC_LOAD;
            issue(r, 1'b0);
            r = make_req(t, reg_idx_t'($urandom_range(31, 24)), ld,
                         reg_idx_t'($urandom_range(31, 24)));
            r.i_type = 1'b0;
            issue(r, 1'b0);
        end
        end_test();
    endtask

    task automatic jumps_and_links();
        ex_req_t    r;
        thread_id_t t;
        reg_idx_t   sa;
        begin_test("branches");
        for (int i = 0; i < N_BR; i++) begin
            t  = $urandom;
            sa = $urandom_range(7, 0);
            r  = make_req(t, reg_idx_t'($urandom_range(15, 8)), sa,
                          ($urandom_range(3, 0) == 0) ? sa : reg_idx_t'($urandom_range(7, 0)));
            r.i_type      = 1'b0;
            r.alu_op      = ALU_SUB;
            r.jmp_cond    = jmp_cond_t'($urandom_range(5, 0));
            r.wr_en       = $urandom;
            r.init_thread = ($urandom_range(7, 0) == 0);
            r.new_tid     = $urandom;
            if ((r.jmp_cond == JC_JAL) || (r.jmp_cond == JC_JR) || r.init_thread) begin
                r.wr_en = 1'b1;
            end
            issue(r, 1'b0);
        end
        end_test();
    endtask

    task automatic flushed_requests();
        ex_req_t r;
        begin_test("flush");
        for (int i = 0; i < N_FL; i++) begin
            r = make_req(thread_id_t'($urandom), reg_idx_t'($urandom_range(15, 8)),
                         reg_idx_t'($urandom_range(7, 0)), reg_idx_t'($urandom_range(7, 0)));
            issue(r, i % 2 == 0);       // even requests are killed in execute
        end
        end_test();
    endtask

    // ******************************************************************
    initial begin
        word_t v;
        void'($urandom(32'h50fa_4a5d));
        rst_n   = 1'b0;
        ex_req  = '0;
        flush   = 1'b0;
        exp_mem = '0;
        exp_wb  = '0;
        n_pass  = 0;
        n_fail  = 0;
        for (int t = 0; t < 8; t++) begin
            for (int i = 0; i < 32; i++) begin
                v = $urandom;
                arch_rf[t][i]      = v;
                committed_rf[t][i] = v;
            end
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem_model[i] = '0;         // the DUT clears its memory in reset
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        random_alu_ops();
        dependent_chains();
        thread_isolation();
        load_use();
        jumps_and_links();
        flushed_requests();
        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("watchdog expired after %0d cycles with tests still running", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
hdl/mt_pkg.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/hazard_ctrl.sv
hdl/exe_stage.sv
hdl/mem_wb_stage.sv
hdl/exe_top.sv
verification/exe_tb.sv
